/* Makefile */
SIM      = verilator
TOP      = tb_vsdma
FLIST    = project.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
OBJDIR   = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* project.f */
vsdma_pkg.sv
vsdma_fs_cap.sv
vsdma_burst_seq.sv
vsdma_wr_fifo.sv
vsdma_rd_fifo.sv
vsdma_ctrl_top.sv
tb_vsdma_asserts.sv
tb_vsdma.sv

/* tb_vsdma.sv */
// testbench with clock, reset, pixel source, DMA engine models, tests and watchdog
`timescale 1ns/1ps

module tb_vsdma;

    import vsdma_pkg::*;

    localparam logic [AXI_ADDR_W-1:0] W_BASE = 28'h0;
    localparam logic [AXI_ADDR_W-1:0] R_BASE = 28'h100;
    localparam int FRAME_PIX       = 128;                   // 32 pixels x 4 lines
    localparam int BURSTS          = 8;                     // 4 lines x 2 bursts
    localparam int BURST_WORDS     = 4;                     // 32 pixels x 32 bits / 128 / 2
    localparam int FRAME_BUDGET    = 400;                   // cycles per frame, generous
    localparam int WATCHDOG_CYCLES = 10 * FRAME_BUDGET;     // 7 frames, flush test, reset

    logic ui_clk, ui_rstn;
    logic w_fs_i, w_wren_i, w_busy_i, w_valid_i, w_full_o;
    logic r_fs_i, r_rden_i, r_busy_i, r_valid_i, r_empty_o;
    logic [PIX_W-1:0]      w_data_i, r_data_o;
    logic [BUFN_W-1:0]     w_buf_i, r_buf_i, w_sync_cnt_o, r_sync_cnt_o;
    logic [AXI_DATA_W-1:0] w_wdata_o, r_rdata_i;
    dma_cmd_t              w_cmd_o, r_cmd_o;

    logic [31:0]      lfsr_q = 32'ha550;
    logic [PIX_W-1:0] w_exp[$];     // pixels written, not yet seen on the bus
    logic [PIX_W-1:0] r_exp[$];     // pixels supplied, not yet read
    int w_bursts = 0;
    int r_bursts = 0;
    int checks   = 0;
    int errors   = 0;

    vsdma_ctrl_top #(.W_BASE_ADDR(W_BASE), .R_BASE_ADDR(R_BASE)) dut0 (.*);

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ui_clk);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    task automatic wait_clk();
        @(posedge ui_clk);
        #1;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic get_pixel(output logic [PIX_W-1:0] p);
        p = '0;
        for (int i = 0; i < PIX_W; i++) begin
            lfsr_q = lfsr_next(lfsr_q);        // one step per bit
            p = {p[PIX_W-2:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [AXI_ADDR_W-1:0] burst_addr(input logic [AXI_ADDR_W-1:0] base,
                                                         input logic [BUFN_W-1:0] bsel,
                                                         input int k);
        return base + (AXI_ADDR_W'(bsel) << DSIZE_BITS) + AXI_ADDR_W'((k / 2) * 64 + (k % 2) * 16);
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input bit ok);
        checks++;
        assert (ok) else begin
            $display("check failed: %s", what);
            errors++;
        end
    endtask

    task automatic check_word(input logic [AXI_DATA_W-1:0] got);
        logic [AXI_DATA_W-1:0] exp;
        if (w_exp.size() < PIX_PER_BEAT) begin
            check_true("write beat came before its pixels were written", 1'b0);
        end else begin
            for (int i = 0; i < PIX_PER_BEAT; i++) begin
                exp[i*PIX_W +: PIX_W] = w_exp.pop_front();  // first pixel lowest
            end
            check_value("w_wdata_o", got, exp);
        end
    endtask

    // write DMA engine, stores bursts from the write FIFO
    initial begin : write_engine
        forever begin
            wait_clk();
            if (w_cmd_o.req === 1'b1) begin
                check_value("w_cmd_o.addr", 128'(w_cmd_o.addr),
                            128'(burst_addr(W_BASE, w_buf_i, w_bursts)));
                check_value("w_cmd_o.size", 128'(w_cmd_o.size), 128'(BURST_WORDS));
                w_bursts++;     // counted at the request
                repeat (2) wait_clk();
                w_busy_i = 1'b1;
                while (int'(dut0.w_level) < int'(w_cmd_o.size)) wait_clk();
                for (int i = 0; i < int'(w_cmd_o.size); i++) begin
                    w_valid_i = 1'b1;
                    check_word(w_wdata_o);
                    wait_clk();
                end
                w_valid_i = 1'b0;
                repeat (2) wait_clk();
                w_busy_i = 1'b0;
            end
        end
    end

    // read DMA engine, returns LFSR words
    initial begin : read_engine
        logic [AXI_DATA_W-1:0] word;
        forever begin
            wait_clk();
            if (r_cmd_o.req === 1'b1) begin
                check_value("r_cmd_o.addr", 128'(r_cmd_o.addr),
                            128'(burst_addr(R_BASE, r_buf_i, r_bursts)));
                check_value("r_cmd_o.size", 128'(r_cmd_o.size), 128'(BURST_WORDS));
                r_bursts++;     // counted at the request
                repeat (2) wait_clk();
                r_busy_i = 1'b1;
                for (int i = 0; i < int'(r_cmd_o.size); i++) begin
                    for (int j = 0; j < PIX_PER_BEAT; j++) begin
                        get_pixel(word[j*PIX_W +: PIX_W]);
                        r_exp.push_back(word[j*PIX_W +: PIX_W]);
                    end
                    r_rdata_i = word;
                    r_valid_i = 1'b1;
                    wait_clk();
                end
                r_valid_i = 1'b0;
                repeat (2) wait_clk();
                r_busy_i = 1'b0;
            end
        end
    end

    task automatic pulse_fs(input bit is_read);
        if (is_read) r_fs_i = 1'b1;
        else w_fs_i = 1'b1;
        repeat (4) wait_clk();
        r_fs_i = 1'b0;
        w_fs_i = 1'b0;
    endtask

    task automatic wait_flush(input bit is_read);
        while (!(is_read ? dut0.r_flush : dut0.w_flush)) wait_clk();
        while (is_read ? dut0.r_flush : dut0.w_flush) wait_clk();
    endtask

    task automatic feed_pixels(input int n);
        logic [PIX_W-1:0] p;
        int sent;
        sent = 0;
        while (sent < n) begin
            if (!w_full_o) begin
                get_pixel(p);
                w_data_i = p;
                w_wren_i = 1'b1;
                w_exp.push_back(p);
                sent++;
            end else begin
                w_wren_i = 1'b0;   // hold while full
            end
            wait_clk();
        end
        w_wren_i = 1'b0;
    endtask

    task automatic read_pixels(input int n);
        int  got;
        bit  fired;
        got   = 0;
        fired = 1'b0;
        while (got < n) begin
            wait_clk();
            if (fired) begin
                check_value("r_data_o", 128'(r_data_o), 128'(r_exp.pop_front()));
                got++;
            end
            r_rden_i = !r_empty_o && (got < n);
            fired    = r_rden_i;
        end
    endtask

    task automatic run_write_frame(input logic [BUFN_W-1:0] bsel, input bit mid_fs,
                                   input logic [BUFN_W-1:0] exp_sync);
        w_buf_i  = bsel;
        w_bursts = 0;
        w_exp.delete();
        pulse_fs(1'b0);
        wait_flush(1'b0);
        check_value("w_sync_cnt_o", 128'(w_sync_cnt_o), 128'(exp_sync));
        fork
            feed_pixels(FRAME_PIX);
            if (mid_fs) begin
                while (w_bursts < 3) wait_clk();
                pulse_fs(1'b0);    // lands inside a transfer
            end
        join
        while (w_bursts < BURSTS) wait_clk();
        repeat (20) wait_clk();
        check_value("w_bursts", 128'(w_bursts), 128'(BURSTS));
        check_value("w_sync_cnt_o", 128'(w_sync_cnt_o), 128'(exp_sync));
        check_true("all written pixels appeared on the bus", w_exp.size() == 0);
    endtask

    task automatic run_read_frame(input logic [BUFN_W-1:0] bsel,
                                  input logic [BUFN_W-1:0] exp_sync);
        r_buf_i  = bsel;
        r_bursts = 0;
        r_exp.delete();
        pulse_fs(1'b1);
        wait_flush(1'b1);
        check_value("r_sync_cnt_o", 128'(r_sync_cnt_o), 128'(exp_sync));
        read_pixels(FRAME_PIX);
        check_true("read FIFO empty after the whole frame", r_empty_o);
        while (r_bursts < BURSTS) wait_clk();
        repeat (20) wait_clk();
        check_value("r_bursts", 128'(r_bursts), 128'(BURSTS));
    endtask

    task automatic flush_test();
        logic [PIX_W-1:0] p;
        bit req_seen;
        req_seen = 1'b0;
        w_wren_i = 1'b1;
        repeat (70) begin
            get_pixel(p);
            w_data_i = p;
            wait_clk();
        end
        w_wren_i = 1'b0;
        check_true("w_full_o high after 70 writes with no DMA service", w_full_o);
        check_value("w_level", 128'(dut0.w_level), 128'(16));
        w_fs_i = 1'b1;
        while (!dut0.w_flush) wait_clk();
        w_fs_i = 1'b0;
        while (dut0.w_flush) begin
            if (w_cmd_o.req) req_seen = 1'b1;
            wait_clk();
        end
        check_true("no write request during flush", !req_seen);
        check_value("w_level", 128'(dut0.w_level), 128'(0));
        check_true("w_full_o low after flush", !w_full_o);
        check_value("w_sync_cnt_o", 128'(w_sync_cnt_o), 128'(1));
    endtask

    task automatic report_test(input int n, input string name, input int base);
        if (errors == base) $display("test %0d %s: ok", n, name);
        else $display("test %0d %s: %0d errors", n, name, errors - base);
    endtask

    initial begin : main
        int base;
        ui_rstn   = 1'b0;
        w_fs_i    = 1'b0;
        w_wren_i  = 1'b0;
        w_data_i  = '0;
        w_buf_i   = '0;
        w_busy_i  = 1'b0;
        w_valid_i = 1'b0;
        r_fs_i    = 1'b0;
        r_rden_i  = 1'b0;
        r_buf_i   = '0;
        r_busy_i  = 1'b0;
        r_valid_i = 1'b0;
        r_rdata_i = '0;
        repeat (16) @(posedge ui_clk);
        #1 ui_rstn = 1'b1;
        wait_clk();

        base = errors;
        check_true("reset state of flags, counters and requests",
                   !w_full_o && r_empty_o && !w_cmd_o.req && !r_cmd_o.req &&
                   w_sync_cnt_o == 8'd0 && r_sync_cnt_o == 8'd0);
        run_write_frame(8'd5, 1'b0, 8'd1);
        report_test(1, "write addresses and packing", base);
        base = errors;
        run_read_frame(8'd2, 8'd1);
        report_test(2, "read addresses and unpacking", base);
        base = errors;
        run_write_frame(8'd1, 1'b1, 8'd2);
        run_write_frame(8'd0, 1'b0, 8'd0);
        report_test(3, "write sync counter and ignored frame start", base);
        base = errors;
        run_read_frame(8'd3, 8'd2);
        run_read_frame(8'd1, 8'd0);
        run_read_frame(8'd0, 8'd1);
        report_test(4, "read sync counter", base);
        base = errors;
        flush_test();
        report_test(5, "flush and back-pressure", base);

        $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.asserts0.fail_cnt);
        if (errors == 0 && dut0.asserts0.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tb_vsdma_asserts.sv */
// concurrent checks on the DMA request handshake and the read flush, bound to the controller top
`timescale 1ns/1ps

module tb_vsdma_asserts (
    input logic                                ui_clk,
    input logic                                ui_rstn,
    input vsdma_pkg::dma_cmd_t                 w_cmd_i,
    input logic                                w_busy_i,
    input vsdma_pkg::dma_cmd_t                 r_cmd_i,
    input logic                                r_busy_i,
    input logic                                r_flush_i,
    input logic [vsdma_pkg::BURST_LEN_W-1:0]   r_level_i,
    input logic                                r_empty_i
);

    int fail_cnt = 0;   // read by the testbench top

    // request drops on the edge after busy is seen
    w_req_drop: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        $rose(w_busy_i) |=> !w_cmd_i.req)
        else begin $error("write request still high after busy rose"); fail_cnt++; end

    r_req_drop: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        $rose(r_busy_i) |=> !r_cmd_i.req)
        else begin $error("read request still high after busy rose"); fail_cnt++; end

    w_cmd_hold: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        (w_busy_i && $past(w_busy_i)) |-> $stable(w_cmd_i.addr))
        else begin $error("write command changed while busy"); fail_cnt++; end

    r_cmd_hold: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        (r_busy_i && $past(r_busy_i)) |-> $stable(r_cmd_i.addr))
        else begin $error("read command changed while busy"); fail_cnt++; end

    // read FIFO storage stays clear through the flush and just after it
    r_flush_empty: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
        $past(r_flush_i) |-> ((r_level_i == '0) && r_empty_i))
        else begin $error("read FIFO not empty during flush"); fail_cnt++; end

endmodule

bind vsdma_ctrl_top tb_vsdma_asserts asserts0 (
    .ui_clk    (ui_clk),
    .ui_rstn   (ui_rstn),
    .w_cmd_i   (w_cmd_o),
    .w_busy_i  (w_busy_i),
    .r_cmd_i   (r_cmd_o),
    .r_busy_i  (r_busy_i),
    .r_flush_i (r_flush),
    .r_level_i (r_level),
    .r_empty_i (r_empty_o)
);

/* vsdma_burst_seq.sv */
// per-channel frame sequencer with FIFO flush, burst request and address stepping
`timescale 1ns/1ps

module vsdma_burst_seq #(
    parameter int                              X_SIZE    = 32,
    parameter int                              X_STRIDE  = 64,
    parameter int                              Y_SIZE    = 4,
    parameter int                              X_DIV     = 2,
    parameter int                              BUF_COUNT = 3,
    parameter logic [vsdma_pkg::AXI_ADDR_W-1:0] BASE_ADDR = '0,
    parameter bit                              IS_READ   = 1'b0
) (
    input  logic                              ui_clk,
    input  logic                              ui_rstn,
    input  logic                              fs_start_i,
    input  logic [vsdma_pkg::BUFN_W-1:0]      buf_i,
    input  logic [vsdma_pkg::BURST_LEN_W-1:0] level_i,
    input  logic                              busy_i,
    output vsdma_pkg::dma_cmd_t               cmd_o,
    output logic                              flush_o,
    output logic [vsdma_pkg::BUFN_W-1:0]      sync_cnt_o
);

    import vsdma_pkg::*;

    localparam int BURST    = (X_SIZE * PIX_W / AXI_DATA_W) / X_DIV;   // words per burst
    localparam int ADDR_INC = (X_SIZE * (PIX_W / 32)) / X_DIV;
    localparam int LAST_INC = (X_STRIDE - X_SIZE) * (PIX_W / 32) + ADDR_INC;
    localparam int BURSTS   = Y_SIZE * X_DIV;                          // bursts per frame
    localparam int THRESH   = BURST - 2;
    localparam int DIV_W    = $clog2(X_DIV) + 1;
    localparam int FCNT_W   = $clog2(FLUSH_CYCLES + 2);

    seq_state_e             state_q;
    logic [DSIZE_BITS-1:0]  addr_q;     // offset inside the buffer
    logic [BURST_LEN_W-1:0] bcnt_q;     // bursts done this frame
    logic [DIV_W-1:0]       div_q;      // part-burst within the line
    logic [FCNT_W-1:0]      fcnt_q;
    logic [BUFN_W-1:0]      bufn_q;
    logic                   req_q;
    logic                   fill_ok_q;

    // fill rule, write side waits for data and read side for room
    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            fill_ok_q <= 1'b0;
        end else if (IS_READ) begin
            fill_ok_q <= !flush_o && (int'(level_i) < THRESH);
        end else begin
            fill_ok_q <= !flush_o && (int'(level_i) > THRESH);
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            state_q    <= SEQ_IDLE;
            addr_q     <= '0;
            bcnt_q     <= '0;
            div_q      <= '0;
            fcnt_q     <= '0;
            bufn_q     <= '0;
            req_q      <= 1'b0;
            flush_o    <= 1'b0;
            sync_cnt_o <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    addr_q <= '0;
                    bcnt_q <= '0;
                    div_q  <= '0;
                    fcnt_q <= '0;
                    if (fs_start_i) begin
                        state_q <= SEQ_FLUSH;
                        if (sync_cnt_o < BUFN_W'(BUF_COUNT - 1)) begin
                            sync_cnt_o <= sync_cnt_o + 1'b1;
                        end else begin
                            sync_cnt_o <= '0;   // wrap over buffer ring
                        end
                    end
                end
                SEQ_FLUSH: begin
                    bufn_q <= buf_i;            // buffer chosen by user
                    fcnt_q <= fcnt_q + 1'b1;
                    if (fcnt_q < FCNT_W'(FLUSH_CYCLES)) begin
                        flush_o <= 1'b1;
                    end else if (fcnt_q == FCNT_W'(FLUSH_CYCLES)) begin
                        flush_o <= 1'b0;
                    end else begin
                        state_q <= SEQ_REQ;
                    end
                end
                SEQ_REQ: begin
                    if (!busy_i && fill_ok_q) begin
                        req_q <= 1'b1;
                    end else if (busy_i) begin
                        req_q   <= 1'b0;        // engine took the burst
                        state_q <= SEQ_XFER;
                    end
                end
                SEQ_XFER: begin
                    if (!busy_i) begin
                        if (bcnt_q == BURST_LEN_W'(BURSTS - 1)) begin
                            state_q <= SEQ_IDLE;
                        end else begin
                            bcnt_q  <= bcnt_q + 1'b1;
                            state_q <= SEQ_REQ;
                            if (div_q < DIV_W'(X_DIV - 1)) begin
                                addr_q <= addr_q + DSIZE_BITS'(ADDR_INC);
                                div_q  <= div_q + 1'b1;
                            end else begin
                                addr_q <= addr_q + DSIZE_BITS'(LAST_INC);  // jump to next line
                                div_q  <= '0;
                            end
                        end
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // buffer index sits above the in-buffer offset
    assign cmd_o.addr = BASE_ADDR + AXI_ADDR_W'({bufn_q, addr_q});
    assign cmd_o.req  = req_q;
    assign cmd_o.size = BURST_LEN_W'(BURST);

endmodule

/* vsdma_ctrl_top.sv */
// video DMA controller top joining the write and read channels
`timescale 1ns/1ps

module vsdma_ctrl_top #(
    parameter int                              W_X_SIZE     = 32,
    parameter int                              W_X_STRIDE   = 64,
    parameter int                              W_Y_SIZE     = 4,
    parameter int                              W_X_DIV      = 2,
    parameter int                              W_BUF_COUNT  = 3,
    parameter logic [vsdma_pkg::AXI_ADDR_W-1:0] W_BASE_ADDR  = 'h0,
    parameter int                              W_FIFO_DEPTH = 16,
    parameter int                              R_X_SIZE     = 32,
    parameter int                              R_X_STRIDE   = 64,
    parameter int                              R_Y_SIZE     = 4,
    parameter int                              R_X_DIV      = 2,
    parameter int                              R_BUF_COUNT  = 3,
    parameter logic [vsdma_pkg::AXI_ADDR_W-1:0] R_BASE_ADDR  = 'h100,
    parameter int                              R_FIFO_DEPTH = 16
) (
    input  logic                             ui_clk,
    input  logic                             ui_rstn,
    // write side user port
    input  logic                             w_fs_i,
    input  logic                             w_wren_i,
    input  logic [vsdma_pkg::PIX_W-1:0]      w_data_i,
    input  logic [vsdma_pkg::BUFN_W-1:0]     w_buf_i,
    output logic [vsdma_pkg::BUFN_W-1:0]     w_sync_cnt_o,
    output logic                             w_full_o,
    // write side DMA engine
    output vsdma_pkg::dma_cmd_t              w_cmd_o,
    input  logic                             w_busy_i,
    input  logic                             w_valid_i,
    output logic [vsdma_pkg::AXI_DATA_W-1:0] w_wdata_o,
    // read side user port
    input  logic                             r_fs_i,
    input  logic                             r_rden_i,
    input  logic [vsdma_pkg::BUFN_W-1:0]     r_buf_i,
    output logic [vsdma_pkg::PIX_W-1:0]      r_data_o,
    output logic [vsdma_pkg::BUFN_W-1:0]     r_sync_cnt_o,
    output logic                             r_empty_o,
    // read side DMA engine
    output vsdma_pkg::dma_cmd_t              r_cmd_o,
    input  logic                             r_busy_i,
    input  logic                             r_valid_i,
    input  logic [vsdma_pkg::AXI_DATA_W-1:0] r_rdata_i
);

    import vsdma_pkg::*;

    logic                   w_fs_start, r_fs_start;
    logic                   w_flush, r_flush;
    logic [BURST_LEN_W-1:0] w_level, r_level;

    vsdma_fs_cap wr_fs_cap0 (.ui_clk, .ui_rstn, .fs_i(w_fs_i), .fs_start_o(w_fs_start));
    vsdma_fs_cap rd_fs_cap0 (.ui_clk, .ui_rstn, .fs_i(r_fs_i), .fs_start_o(r_fs_start));

    vsdma_burst_seq #(
        .X_SIZE(W_X_SIZE), .X_STRIDE(W_X_STRIDE), .Y_SIZE(W_Y_SIZE), .X_DIV(W_X_DIV),
        .BUF_COUNT(W_BUF_COUNT), .BASE_ADDR(W_BASE_ADDR), .IS_READ(1'b0)
    ) wr_seq0 (
        .ui_clk, .ui_rstn, .fs_start_i(w_fs_start), .buf_i(w_buf_i), .level_i(w_level),
        .busy_i(w_busy_i), .cmd_o(w_cmd_o), .flush_o(w_flush), .sync_cnt_o(w_sync_cnt_o)
    );

    vsdma_burst_seq #(
        .X_SIZE(R_X_SIZE), .X_STRIDE(R_X_STRIDE), .Y_SIZE(R_Y_SIZE), .X_DIV(R_X_DIV),
        .BUF_COUNT(R_BUF_COUNT), .BASE_ADDR(R_BASE_ADDR), .IS_READ(1'b1)
    ) rd_seq0 (
        .ui_clk, .ui_rstn, .fs_start_i(r_fs_start), .buf_i(r_buf_i), .level_i(r_level),
        .busy_i(r_busy_i), .cmd_o(r_cmd_o), .flush_o(r_flush), .sync_cnt_o(r_sync_cnt_o)
    );

    vsdma_wr_fifo #(.FIFO_DEPTH(W_FIFO_DEPTH)) wr_fifo0 (
        .ui_clk, .ui_rstn, .flush_i(w_flush), .wren_i(w_wren_i), .pix_i(w_data_i),
        .pop_i(w_valid_i), .word_o(w_wdata_o), .level_o(w_level), .full_o(w_full_o)
    );

    vsdma_rd_fifo #(.FIFO_DEPTH(R_FIFO_DEPTH)) rd_fifo0 (
        .ui_clk, .ui_rstn, .flush_i(r_flush), .push_i(r_valid_i), .word_i(r_rdata_i),
        .rden_i(r_rden_i), .pix_o(r_data_o), .level_o(r_level), .empty_o(r_empty_o)
    );

endmodule

/* vsdma_fs_cap.sv */
// frame-sync synchronizer with one-cycle frame-start pulse
`timescale 1ns/1ps

module vsdma_fs_cap (
    input  logic ui_clk,
    input  logic ui_rstn,
    input  logic fs_i,
    output logic fs_start_o
);

    logic fs_meta;  // first sync stage
    logic fs_sync;  // second sync stage
    logic fs_prev;  // delayed copy for edge detect

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn) begin
            fs_meta    <= 1'b0;
            fs_sync    <= 1'b0;
            fs_prev    <= 1'b0;
            fs_start_o <= 1'b0;
        end else begin
            fs_meta    <= fs_i;
            fs_sync    <= fs_meta;
            fs_prev    <= fs_sync;
            fs_start_o <= fs_sync & ~fs_prev;   // rising edge only
        end
    end

endmodule

/* vsdma_pkg.sv */
// shared widths, sequencer state type and DMA command struct for the video DMA controller
package vsdma_pkg;

    // bus and pixel geometry
    localparam int AXI_DATA_W   = 128;                  // one bus word
    localparam int AXI_ADDR_W   = 28;                   // memory address
    localparam int PIX_W        = 32;                   // one pixel
    localparam int PIX_PER_BEAT = AXI_DATA_W / PIX_W;   // pixels in a bus word

    // frame buffer addressing
    localparam int DSIZE_BITS   = 22;                   // in-buffer address width
    localparam int BUFN_W       = 8;                    // buffer index and sync counter

    localparam int FLUSH_CYCLES = 16;                   // FIFO clear hold time
    localparam int BURST_LEN_W  = 16;                   // burst size field, also FIFO level

    // per-channel sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,   // wait for frame start
        SEQ_FLUSH = 2'd1,   // clear FIFO, latch buffer
        SEQ_REQ   = 2'd2,   // raise request on fill level
        SEQ_XFER  = 2'd3    // burst in flight
    } seq_state_e;

    // Command handed to the external DMA engine. The address and size are
    // held constant from the rising request until busy falls again.
    typedef struct packed {
        logic [AXI_ADDR_W-1:0]  addr;   // burst start address
        logic                   req;    // request level
        logic [BURST_LEN_W-1:0] size;   // burst length in bus words
    } dma_cmd_t;

endpackage

/* vsdma_rd_fifo.sv */
// read-side word FIFO with pixel unpacker, fill level and empty flag
`timescale 1ns/1ps

module vsdma_rd_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              ui_clk,
    input  logic                              ui_rstn,
    input  logic                              flush_i,
    input  logic                              push_i,
    input  logic [vsdma_pkg::AXI_DATA_W-1:0]  word_i,
    input  logic                              rden_i,
    output logic [vsdma_pkg::PIX_W-1:0]       pix_o,
    output logic [vsdma_pkg::BURST_LEN_W-1:0] level_o,
    output logic                              empty_o
);

    import vsdma_pkg::*;

    localparam int AW  = $clog2(FIFO_DEPTH);
    localparam int PCW = $clog2(PIX_PER_BEAT);

    logic [AXI_DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AXI_DATA_W-1:0] cur_q;       // word being unpacked
    logic [AXI_DATA_W-1:0] src_word;
    logic [PCW-1:0]        idx_q;       // next pixel in cur_q
    logic [PCW-1:0]        src_idx;
    logic                  cur_vld_q;
    logic [AW-1:0]         wr_ptr_q;
    logic [AW-1:0]         rd_ptr_q;
    logic [AW:0]           count_q;
    logic                  push;
    logic                  pop;
    logic                  rd_fire;

    assign empty_o  = flush_i || (!cur_vld_q && (count_q == '0));
    assign rd_fire  = rden_i && !empty_o;
    assign pop      = rd_fire && !cur_vld_q;   // pull a fresh word
    assign push     = push_i && (count_q != (AW+1)'(FIFO_DEPTH));
    assign level_o  = BURST_LEN_W'(count_q);
    assign src_word = cur_vld_q ? cur_q : mem[rd_ptr_q];
    assign src_idx  = cur_vld_q ? idx_q : '0;

    always_ff @(posedge ui_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= word_i;
        end
        if (pop) begin
            cur_q <= mem[rd_ptr_q];
        end
        if (rd_fire) begin
            pix_o <= src_word[src_idx*PIX_W +: PIX_W];  // low pixel first
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn || flush_i) begin
            idx_q     <= '0;
            cur_vld_q <= 1'b0;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q  <= rd_ptr_q + 1'b1;
                idx_q     <= PCW'(1);
                cur_vld_q <= 1'b1;
            end else if (rd_fire) begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == PCW'(PIX_PER_BEAT - 1)) begin
                    cur_vld_q <= 1'b0;  // word used up
                end
            end
            count_q <= count_q + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

endmodule

/* vsdma_wr_fifo.sv */
// write-side pixel packer and show-ahead word FIFO with fill level
`timescale 1ns/1ps

module vsdma_wr_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              ui_clk,
    input  logic                              ui_rstn,
    input  logic                              flush_i,
    input  logic                              wren_i,
    input  logic [vsdma_pkg::PIX_W-1:0]       pix_i,
    input  logic                              pop_i,
    output logic [vsdma_pkg::AXI_DATA_W-1:0]  word_o,
    output logic [vsdma_pkg::BURST_LEN_W-1:0] level_o,
    output logic                              full_o
);

    import vsdma_pkg::*;

    localparam int AW    = $clog2(FIFO_DEPTH);
    localparam int PCW   = $clog2(PIX_PER_BEAT);
    localparam int LAST  = PIX_PER_BEAT - 1;

    logic [AXI_DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AXI_DATA_W-1:0] pack_q;      // partly filled word
    logic [AXI_DATA_W-1:0] push_word;
    logic [PCW-1:0]        pcnt_q;      // next pixel slot
    logic [AW-1:0]         wr_ptr_q;
    logic [AW-1:0]         rd_ptr_q;
    logic [AW:0]           count_q;
    logic                  wr_ok;
    logic                  push;
    logic                  pop;

    assign full_o  = !flush_i && (count_q == (AW+1)'(FIFO_DEPTH));
    assign wr_ok   = wren_i && !full_o;
    assign push    = wr_ok && (pcnt_q == PCW'(LAST));
    assign pop     = pop_i && (count_q != '0);
    assign word_o  = mem[rd_ptr_q];     // oldest word always visible
    assign level_o = BURST_LEN_W'(count_q);

    // last pixel goes straight into the pushed word
    always_comb begin
        push_word = pack_q;
        push_word[LAST*PIX_W +: PIX_W] = pix_i;
    end

    always_ff @(posedge ui_clk) begin
        if (wr_ok) begin
            pack_q[pcnt_q*PIX_W +: PIX_W] <= pix_i;
        end
        if (push) begin
            mem[wr_ptr_q] <= push_word;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!ui_rstn || flush_i) begin
            pcnt_q   <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) begin
                pcnt_q <= pcnt_q + 1'b1;    // wraps after a full word
            end
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

endmodule
